/* Bender.yml */
package:
  name: sort_buffer

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/sort_pkg.sv
      - rtl/store_if.sv
      - rtl/sort_ctrl.sv
      - rtl/elem_store.sv
      - rtl/oddeven_stage.sv
      - rtl/out_streamer.sv
      - rtl/sort_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/sort_checker.sv
      - testbench/tb_sort.sv

/* rtl/elem_store.sv */
`timescale 1ns/100ps

`include "sort_defines.svh"

module elem_store (
	input  logic  clk,
	input  logic  rst_n,
	store_if.store bus
);

	sort_pkg::entries_t entries_q;
	sort_pkg::cnt_t     count_q;
	logic               full;
	logic               empty;

	assign full        = (count_q == sort_pkg::cnt_t'(`SORT_DEPTH));
	assign empty       = (count_q == '0);
	assign bus.count   = count_q;
	assign bus.entries = entries_q;

	// ----------------------------------------
	// Array update
	// ----------------------------------------

	// Slots at count and above stay zero at all times
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			entries_q <= '0;
			count_q   <= '0;
		end else begin
			case (bus.cmd)
				sort_pkg::CMD_PUSH: begin
					// Push to a full buffer dropped
					if (!full) begin
						entries_q[count_q] <= bus.push_data;
						count_q            <= count_q + sort_pkg::cnt_t'(1);
					end
				end
				sort_pkg::CMD_POP_NEW: begin
					// Stack pop, newest sits at count-1
					if (!empty) begin
						entries_q[count_q - sort_pkg::cnt_t'(1)] <= '0;
						count_q <= count_q - sort_pkg::cnt_t'(1);
					end
				end
				sort_pkg::CMD_POP_OLD: begin
					// Queue pop, everything moves down one slot
					if (!empty) begin
						entries_q <= {sort_pkg::elem_t'(0), entries_q[`SORT_DEPTH-1:1]};
						count_q   <= count_q - sort_pkg::cnt_t'(1);
					end
				end
				sort_pkg::CMD_SORT: begin
					entries_q <= bus.sorted;
				end
				sort_pkg::CMD_CLEAR: begin
					entries_q <= '0;
					count_q   <= '0;
				end
				default: begin
					// Hold
					entries_q <= entries_q;
				end
			endcase
		end
	end

endmodule

/* rtl/oddeven_stage.sv */
`timescale 1ns/100ps

`include "sort_defines.svh"

module oddeven_stage (
	store_if.sorter bus
);

	// ----------------------------------------
	// One compare-swap pass
	// ----------------------------------------

	// Pairs are disjoint within a pass, so each reads the old array
	always_comb begin
		bus.sorted = bus.entries;
		for (int i = 0; i < `SORT_DEPTH - 1; i++) begin
			// Pair start must match parity, both slots valid
			if ((i % 2) == bus.parity && (i + 1) < bus.count) begin
				// Larger value moves toward index 0
				if (bus.entries[i] < bus.entries[i+1]) begin
					bus.sorted[i]   = bus.entries[i+1];
					bus.sorted[i+1] = bus.entries[i];
				end
			end
		end
	end

endmodule

/* rtl/out_streamer.sv */
`timescale 1ns/100ps

`include "sort_defines.svh"

module out_streamer (
	input  logic             clk,
	input  logic             rst_n,
	input  sort_pkg::phase_e phase,
	store_if.reader          bus,
	output logic             out_valid,
	output sort_pkg::elem_t  out,
	output logic             stream_done
);

	localparam int IDX_W = $clog2(`SORT_OUT_LEN);

	logic [IDX_W-1:0] idx;
	logic             streaming;

	assign streaming   = (phase == sort_pkg::PH_OUTPUT);
	// Controller clears the store on this edge
	assign stream_done = streaming && (idx == IDX_W'(`SORT_OUT_LEN - 1));

	// Registered stream, zeros past the array end
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx       <= '0;
			out_valid <= 1'b0;
			out       <= '0;
		end else if (streaming) begin
			idx       <= idx + IDX_W'(1);
			out_valid <= 1'b1;
			out       <= (idx < `SORT_DEPTH) ? bus.entries[idx] : '0;
		end else begin
			idx       <= '0;
			out_valid <= 1'b0;
			out       <= '0;
		end
	end

endmodule

/* rtl/sort_ctrl.sv */
`timescale 1ns/100ps

module sort_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid1,
	input  logic                in_valid2,
	input  logic                mode,
	input  logic [1:0]          op,
	input  sort_pkg::elem_t     in,
	input  logic                stream_done,
	store_if.ctrl               bus,
	output sort_pkg::phase_e    phase
);

	sort_pkg::phase_e     phase_nxt;
	sort_pkg::store_cmd_e cmd;
	sort_pkg::cnt_t       pass_cnt;
	sort_pkg::cnt_t       passes_needed;
	logic                 mode_q;
	logic                 last_pass;

	// ----------------------------------------
	// Pass bookkeeping
	// ----------------------------------------

	// Empty buffer still spends one pass
	assign passes_needed = (bus.count == '0) ? sort_pkg::cnt_t'(1) : bus.count;
	assign last_pass     = (pass_cnt == passes_needed - sort_pkg::cnt_t'(1));

	// Even pass first, then alternate
	assign bus.parity    = pass_cnt[0];
	assign bus.push_data = in;
	assign bus.cmd       = cmd;

	// ----------------------------------------
	// Phase FSM
	// ----------------------------------------

	always_comb begin
		phase_nxt = phase;
		cmd       = sort_pkg::CMD_NONE;
		case (phase)
			sort_pkg::PH_IDLE: begin
				phase_nxt = sort_pkg::PH_COLLECT;
			end
			sort_pkg::PH_COLLECT: begin
				if (in_valid1) begin
					case (op)
						2'd0: cmd = mode_q ? sort_pkg::CMD_POP_OLD : sort_pkg::CMD_POP_NEW;
						2'd1: cmd = sort_pkg::CMD_PUSH;
						2'd2: phase_nxt = sort_pkg::PH_SORT;
						// Op 3 does nothing
						default: cmd = sort_pkg::CMD_NONE;
					endcase
				end
			end
			sort_pkg::PH_SORT: begin
				cmd = sort_pkg::CMD_SORT;
				if (last_pass)
					phase_nxt = sort_pkg::PH_OUTPUT;
			end
			sort_pkg::PH_OUTPUT: begin
				// Buffer empties on the last streamed value
				if (stream_done) begin
					cmd       = sort_pkg::CMD_CLEAR;
					phase_nxt = sort_pkg::PH_IDLE;
				end
			end
			default: phase_nxt = sort_pkg::PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase    <= sort_pkg::PH_COLLECT;
			mode_q   <= 1'b0;
			pass_cnt <= '0;
		end else begin
			phase <= phase_nxt;
			// Mode only taken while collecting, a pop sees the previous value
			if (in_valid2 && phase == sort_pkg::PH_COLLECT)
				mode_q <= mode;
			if (phase == sort_pkg::PH_SORT)
				pass_cnt <= pass_cnt + sort_pkg::cnt_t'(1);
			else
				pass_cnt <= '0;
		end
	end

endmodule

/* rtl/sort_defines.svh */
`ifndef SORT_DEFINES_SVH
`define SORT_DEFINES_SVH

// ----------------------------------------
// Buffer geometry
// ----------------------------------------

// Number of entries held by the buffer
`define SORT_DEPTH 10

// Width of one stored number
`define SORT_DW 5

// ----------------------------------------
// Output stream
// ----------------------------------------

// Values sent per sort command, stored entries first, then zeros
`define SORT_OUT_LEN 10

`endif

/* rtl/sort_pkg.sv */
`include "sort_defines.svh"

package sort_pkg;

	// One stored number
	typedef logic [`SORT_DW-1:0] elem_t;

	// Fill count or index, covers 0 to depth inclusive
	typedef logic [$clog2(`SORT_DEPTH + 1)-1:0] cnt_t;

	// Store commands, one per cycle at most
	typedef enum logic [2:0] {
		CMD_NONE,
		CMD_PUSH,
		CMD_POP_NEW,
		CMD_POP_OLD,
		CMD_SORT,
		CMD_CLEAR
	} store_cmd_e;

	// Controller phases
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_COLLECT,
		PH_SORT,
		PH_OUTPUT
	} phase_e;

	// Whole array, index 0 holds the oldest / largest entry
	typedef elem_t [`SORT_DEPTH-1:0] entries_t;

endpackage

/* rtl/sort_top.sv */
`timescale 1ns/100ps

module sort_top (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid1,
	input  logic            in_valid2,
	input  logic            mode,
	input  logic [1:0]      op,
	input  sort_pkg::elem_t in,
	output logic            out_valid,
	output sort_pkg::elem_t out
);

	sort_pkg::phase_e phase;
	logic             stream_done;

	// Shared element store link
	store_if bus ();

	// Phase FSM, command source for the store
	sort_ctrl i_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid1   (in_valid1),
		.in_valid2   (in_valid2),
		.mode        (mode),
		.op          (op),
		.in          (in),
		.stream_done (stream_done),
		.bus         (bus.ctrl),
		.phase       (phase)
	);

	elem_store i_store (
		.clk   (clk),
		.rst_n (rst_n),
		.bus   (bus.store)
	);

	oddeven_stage i_stage (
		.bus (bus.sorter)
	);

	out_streamer i_stream (
		.clk         (clk),
		.rst_n       (rst_n),
		.phase       (phase),
		.bus         (bus.reader),
		.out_valid   (out_valid),
		.out         (out),
		.stream_done (stream_done)
	);

endmodule

/* rtl/store_if.sv */
`timescale 1ns/100ps

interface store_if;

	// Command and payload from the controller
	sort_pkg::store_cmd_e cmd;
	sort_pkg::elem_t      push_data;
	// 0 = even pairs (0-1, 2-3 ...), 1 = odd pairs (1-2, 3-4 ...)
	logic                 parity;

	// Store state, valid entries sit below count
	sort_pkg::cnt_t       count;
	sort_pkg::entries_t   entries;

	// Array after one compare-swap pass
	sort_pkg::entries_t   sorted;

	// Controller issues commands, watches the fill count
	modport ctrl (output cmd, output push_data, output parity, input count);

	// Store applies commands on the clock edge
	modport store (input cmd, input push_data, input sorted, output count, output entries);

	// Pass sorter is combinational over the live array
	modport sorter (input parity, input count, input entries, output sorted);

	// Output streamer reads the array only
	modport reader (input entries);

endinterface

/* testbench/sort_checker.sv */
`timescale 1ns/100ps

`include "sort_defines.svh"

module sort_checker (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            in_valid1,
	input  logic            in_valid2,
	input  logic            mode,
	input  logic [1:0]      op,
	input  sort_pkg::elem_t in,
	input  logic            out_valid,
	input  sort_pkg::elem_t out,
	output int              mismatch_count,
	output int              protocol_count,
	output logic            busy
);

	// Reference list, index 0 is the oldest entry
	sort_pkg::elem_t model[$];
	sort_pkg::elem_t expected[`SORT_OUT_LEN];
	logic            queue_mode;
	int              pulses;
	int              wait_cycles;

	initial begin
		mismatch_count = 0;
		protocol_count = 0;
		busy           = 1'b0;
	end

	// Pad with zeros, then order largest first
	function automatic void predict_stream();
		sort_pkg::elem_t tmp;
		for (int i = 0; i < `SORT_OUT_LEN; i++)
			expected[i] = (i < model.size()) ? model[i] : '0;
		for (int i = 0; i < `SORT_OUT_LEN; i++) begin
			for (int j = i + 1; j < `SORT_OUT_LEN; j++) begin
				if (expected[j] > expected[i]) begin
					tmp         = expected[i];
					expected[i] = expected[j];
					expected[j] = tmp;
				end
			end
		end
	endfunction

	// ----------------------------------------
	// Sampling on the rising edge
	// ----------------------------------------

	always @(posedge clk) begin
		if (!rst_n) begin
			model.delete();
			queue_mode = 1'b0;
			busy       = 1'b0;
		end else begin
			// Stream in flight, compare each valid value
			if (busy) begin
				if (out_valid) begin
					if (pulses < `SORT_OUT_LEN && out !== expected[pulses]) begin
						$display("MISMATCH out: expected %h, got %h at value %0d",
							expected[pulses], out, pulses);
						mismatch_count++;
					end
					pulses++;
				end else if (pulses > 0) begin
					if (pulses != `SORT_OUT_LEN) begin
						$display("Output stream had %0d valid cycles instead of %0d",
							pulses, `SORT_OUT_LEN);
						protocol_count++;
					end
					busy = 1'b0;
				end else begin
					wait_cycles++;
					if (wait_cycles > `SORT_DEPTH + 6) begin
						$display("No output stream arrived after a sort command");
						protocol_count++;
						busy = 1'b0;
					end
				end
			end
			// Collecting, outputs must be quiet
			if (!busy) begin
				if (out_valid) begin
					$display("out_valid went high with no sort pending");
					protocol_count++;
				end
				if (out !== '0) begin
					$display("MISMATCH out: expected %h, got %h while idle", 5'h00, out);
					mismatch_count++;
				end
				if (in_valid1) begin
					case (op)
						2'd0: begin
							// Empty pop ignored
							if (model.size() > 0)
								model.delete(queue_mode ? 0 : model.size() - 1);
						end
						2'd1: begin
							if (model.size() < `SORT_DEPTH)
								model.push_back(in);
						end
						2'd2: begin
							predict_stream();
							model.delete();
							busy        = 1'b1;
							pulses      = 0;
							wait_cycles = 0;
						end
						default: ;
					endcase
				end
				// New mode applies to later pops only
				if (in_valid2)
					queue_mode = mode;
			end
		end
	end

endmodule

/* testbench/tb_sort.sv */
`timescale 1ns/100ps

`include "sort_defines.svh"

module tb_sort;

	localparam int MAX_ROWS = 80;
	localparam int CLK_NS   = 40;

	logic            clk;
	logic            rst_n;
	logic            in_valid1;
	logic            in_valid2;
	logic            mode;
	logic [1:0]      op;
	sort_pkg::elem_t in;
	logic            out_valid;
	sort_pkg::elem_t out;
	int              mismatch_count;
	int              protocol_count;
	logic            checker_busy;

	// One stimulus row per clock
	logic            row_v1   [MAX_ROWS];
	logic [1:0]      row_op   [MAX_ROWS];
	sort_pkg::elem_t row_data [MAX_ROWS];
	logic            row_v2   [MAX_ROWS];
	logic            row_mode [MAX_ROWS];
	logic            row_rand [MAX_ROWS];
	logic            row_sort [MAX_ROWS];
	int              n_rows;
	int              n_sorts;
	int              watchdog_ns;

	sort_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid1 (in_valid1),
		.in_valid2 (in_valid2),
		.mode      (mode),
		.op        (op),
		.in        (in),
		.out_valid (out_valid),
		.out       (out)
	);

	sort_checker i_checker (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid1      (in_valid1),
		.in_valid2      (in_valid2),
		.mode           (mode),
		.op             (op),
		.in             (in),
		.out_valid      (out_valid),
		.out            (out),
		.mismatch_count (mismatch_count),
		.protocol_count (protocol_count),
		.busy           (checker_busy)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ----------------------------------------
	// Table building
	// ----------------------------------------

	task automatic store_row(input logic v1, input logic [1:0] o, input sort_pkg::elem_t d,
		input logic v2, input logic m, input logic r);
		row_v1[n_rows]   = v1;
		row_op[n_rows]   = o;
		row_data[n_rows] = d;
		row_v2[n_rows]   = v2;
		row_mode[n_rows] = m;
		row_rand[n_rows] = r;
		row_sort[n_rows] = v1 && (o == 2'd2);
		if (row_sort[n_rows])
			n_sorts++;
		n_rows++;
	endtask

	task automatic push_value(input sort_pkg::elem_t d);
		store_row(1'b1, 2'd1, d, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic push_random();
		store_row(1'b1, 2'd1, '0, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic pop_once();
		store_row(1'b1, 2'd0, '0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic set_mode(input logic m);
		store_row(1'b0, 2'd0, '0, 1'b1, m, 1'b0);
	endtask

	task automatic request_sort();
		store_row(1'b1, 2'd2, '0, 1'b0, 1'b0, 1'b0);
	endtask

	// ----------------------------------------
	// Drivers for the rising edge
	// ----------------------------------------

	task automatic drive_idle();
		in_valid1 <= 1'b0;
		in_valid2 <= 1'b0;
		op        <= 2'd0;
		in        <= '0;
		mode      <= 1'b0;
	endtask

	task automatic drive_row(input int i);
		in_valid1 <= row_v1[i];
		op        <= row_op[i];
		in        <= row_rand[i] ? sort_pkg::elem_t'($urandom_range((1 << `SORT_DW) - 1, 0))
			: row_data[i];
		in_valid2 <= row_v2[i];
		mode      <= row_mode[i];
	endtask

	// Stray strobes while the DUT sorts or streams
	task automatic drive_noise();
		in_valid1 <= 1'b1;
		op        <= 2'($urandom_range(3, 0));
		in        <= sort_pkg::elem_t'($urandom_range((1 << `SORT_DW) - 1, 0));
		in_valid2 <= 1'b1;
		mode      <= 1'($urandom_range(1, 0));
	endtask

	// Runs until out_valid has risen and fallen
	task automatic wait_for_stream();
		int highs;
		bit seen_end;
		highs    = 0;
		seen_end = 0;
		while (!seen_end) begin
			@(posedge clk);
			// Noise stops in time to be sampled before collect resumes
			if (highs < `SORT_OUT_LEN - 1)
				drive_noise();
			else
				drive_idle();
			@(negedge clk);
			if (out_valid)
				highs++;
			else if (highs > 0)
				seen_end = 1;
		end
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		in_valid1   = 1'b0;
		in_valid2   = 1'b0;
		mode        = 1'b0;
		op          = 2'd0;
		in          = '0;
		n_rows      = 0;
		n_sorts     = 0;
		watchdog_ns = 0;
		void'($urandom(32'h5e2d_322a));

		// Empty buffer gives ten zeros
		request_sort();
		// Random pushes
		repeat (6) push_random();
		request_sort();
		// Stack pops take the newest
		// Op 3 and a bare op do nothing
		set_mode(1'b0);
		push_value(5'd7);
		push_value(5'd19);
		push_value(5'd3);
		push_value(5'd28);
		push_value(5'd12);
		pop_once();
		pop_once();
		store_row(1'b1, 2'd3, 5'h1f, 1'b0, 1'b0, 1'b0);
		store_row(1'b0, 2'd1, 5'h1e, 1'b0, 1'b0, 1'b0);
		request_sort();
		// Queue pops take the oldest before a switch back to stack
		set_mode(1'b1);
		push_value(5'd9);
		push_value(5'd30);
		push_value(5'd2);
		push_value(5'd17);
		pop_once();
		push_value(5'd25);
		set_mode(1'b0);
		pop_once();
		request_sort();
		// Eleventh push dropped
		set_mode(1'b1);
		repeat (11) push_random();
		request_sort();
		// Pops of an empty buffer dropped
		pop_once();
		pop_once();
		push_value(5'd21);
		request_sort();
		// Full buffer with mixed pops
		repeat (10) push_random();
		pop_once();
		pop_once();
		push_random();
		set_mode(1'b0);
		pop_once();
		request_sort();

		watchdog_ns = (n_rows + 25 * n_sorts) * CLK_NS * 2;

		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		for (int i = 0; i < n_rows; i++) begin
			@(posedge clk);
			drive_row(i);
			if (row_sort[i]) begin
				wait_for_stream();
				repeat (2) @(posedge clk);
			end
		end
		@(posedge clk);
		drive_idle();
		repeat (4) @(posedge clk);
		@(negedge clk);

		if (checker_busy)
			$display("A sort command was still waiting for its stream at the end of the run");
		$display("Error counts: %0d value mismatches, %0d other errors",
			mismatch_count, protocol_count + (checker_busy ? 1 : 0));
		if (mismatch_count == 0 && protocol_count == 0 && !checker_busy) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Watchdog sized from the table
	initial begin
		wait (watchdog_ns > 0);
		#(watchdog_ns);
		$display("Watchdog expired after %0d ns, the DUT stopped responding", watchdog_ns);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+rtl
rtl/sort_pkg.sv
rtl/store_if.sv
rtl/sort_ctrl.sv
rtl/elem_store.sv
rtl/oddeven_stage.sv
rtl/out_streamer.sv
rtl/sort_top.sv
testbench/sort_checker.sv
testbench/tb_sort.sv
